// ==== board_io_pkg.sv ====
////////////////////
// shared types for the board io block
// gpio width is fixed here, the bus structs depend on it
// register map is 4 words of GPIO_WIDTH bits each
////////////////////
`default_nettype none

package board_io_pkg;

	// pin count, one bit per pad in every word below
	localparam int unsigned GPIO_WIDTH = 16;

	typedef logic [GPIO_WIDTH-1:0] gpio_word_t;	// one bit per pin
	typedef logic [1:0] reg_addr_t;			// register select

	// register map
	localparam reg_addr_t ADDR_OUT  = 2'd0;	// output levels
	localparam reg_addr_t ADDR_DIR  = 2'd1;	// drive enables, 1 = drive
	localparam reg_addr_t ADDR_IN   = 2'd2;	// synced pin levels, read only
	localparam reg_addr_t ADDR_EDGE = 2'd3;	// sticky rise flags, write 1 clears

	// command word, held stable by the master until accepted
	typedef struct packed {
		logic       write;	// 1 = write, 0 = read
		reg_addr_t  addr;
		gpio_word_t wdata;	// ignored on reads
	} gpio_cmd_t;

	// response word
	typedef struct packed {
		gpio_word_t rdata;	// zero for writes
	} gpio_rsp_t;

	// reset sequencer states
	typedef enum logic {
		RST_HOLD,	// counting out the hold time
		RST_RUN		// core released
	} rst_state_t;

endpackage

`default_nettype wire

// ==== reset_sequencer.sv ====
////////////////////
// stretches reset2a into the core reset
// core reset lasts at least RESET_HOLD cycles past reset2a
// RESET_HOLD must be 1 or more
////////////////////
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
	parameter int unsigned RESET_HOLD = 16	// extra cycles held after reset2a
) (
	input  logic clock_50mhz_i,
	input  logic reset2a_i,		// external reset, sync, active high
	output logic core_reset_o	// registered, high until RST_RUN
);

	// counter wide enough to hold RESET_HOLD
	localparam int unsigned CNT_W = $clog2(RESET_HOLD + 1);
	localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(RESET_HOLD - 1);

	board_io_pkg::rst_state_t state_q;
	logic [CNT_W-1:0] hold_cnt_q;

	always_ff @(posedge clock_50mhz_i)
	begin
		if (reset2a_i)
		begin
			state_q      <= board_io_pkg::RST_HOLD;	// restart the count
			hold_cnt_q   <= '0;
			core_reset_o <= 1'b1;
		end
		else
		begin
			// one cycle behind the state, so the hold is never short
			core_reset_o <= (state_q != board_io_pkg::RST_RUN);
			case (state_q)
				board_io_pkg::RST_HOLD:
				begin
					if (hold_cnt_q == HOLD_LAST)
						state_q <= board_io_pkg::RST_RUN;	// hold time done
					else
						hold_cnt_q <= hold_cnt_q + 1'b1;
				end
				board_io_pkg::RST_RUN:
				begin
					hold_cnt_q <= hold_cnt_q;	// parked until next reset2a
				end
				default:
				begin
					state_q <= board_io_pkg::RST_HOLD;	// illegal encoding, start over
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== pin_synchronizer.sv ====
////////////////////
// pad input synchronizer with rise detect
// level_o follows a pad after SYNC_STAGES cycles
// floating pads must be resolved on the board
////////////////////
`timescale 1ns/1ps
`default_nettype none

module pin_synchronizer #(
	parameter int unsigned SYNC_STAGES = 2	// flops per pin, 1 or more
) (
	input  logic                     clock_50mhz_i,
	input  logic                     reset_i,	// core reset
	input  board_io_pkg::gpio_word_t pad_i,		// raw pad values, async
	output board_io_pkg::gpio_word_t level_o,	// synced pin levels
	output board_io_pkg::gpio_word_t rise_o		// one cycle pulse per rising edge
);

	// sync chain, stage 0 takes the pad
	board_io_pkg::gpio_word_t sync_q [SYNC_STAGES];
	board_io_pkg::gpio_word_t prev_q;	// last stage, one cycle late

	always_ff @(posedge clock_50mhz_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < SYNC_STAGES; i++)
				sync_q[i] <= '0;
			prev_q <= '0;	// no false rise right after reset
		end
		else
		begin
			sync_q[0] <= pad_i;
			for (int i = 1; i < SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];	// shift along the chain
			prev_q <= sync_q[SYNC_STAGES-1];
		end
	end

	// synced level is the end of the chain
	assign level_o = sync_q[SYNC_STAGES-1];

	// was 0, now 1
	// high only on the first cycle the level reads high
	assign rise_o = sync_q[SYNC_STAGES-1] & ~prev_q;

endmodule

`default_nettype wire

// ==== gpio_regs.sv ====
////////////////////
// gpio register block on a valid/ready cmd/rsp bus
// one command in flight, response one cycle after accept
// edge flags are sticky, write 1 to clear, set beats clear
////////////////////
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
	input  logic                     clock_50mhz_i,
	input  logic                     reset_i,		// core reset

	// command channel
	input  logic                     cmd_valid_i,
	output logic                     cmd_ready_o,
	input  board_io_pkg::gpio_cmd_t  cmd_i,

	// response channel
	output logic                     rsp_valid_o,
	input  logic                     rsp_ready_i,
	output board_io_pkg::gpio_rsp_t  rsp_o,

	// from the synchronizer
	input  board_io_pkg::gpio_word_t level_i,
	input  board_io_pkg::gpio_word_t rise_i,

	// to the pads
	output board_io_pkg::gpio_word_t out_o,
	output board_io_pkg::gpio_word_t dir_o
);

	board_io_pkg::gpio_word_t out_q;	// output levels
	board_io_pkg::gpio_word_t dir_q;	// drive enables
	board_io_pkg::gpio_word_t edge_q;	// sticky rise flags
	board_io_pkg::gpio_rsp_t  rsp_q;	// one entry response slot
	logic                     rsp_valid_q;
	logic                     run_q;	// low through core reset

	logic                     cmd_fire;	// command accepted this cycle
	logic                     rsp_fire;	// response taken this cycle
	board_io_pkg::gpio_word_t rd_data;	// addressed register value
	board_io_pkg::gpio_word_t edge_clr;	// write-one-to-clear mask

	// handshakes
	assign rsp_fire = rsp_valid_q & rsp_ready_i;

	// free slot, or the slot drains this very cycle
	// so a new command can follow each response with no gap
	assign cmd_ready_o = run_q & (~rsp_valid_q | rsp_ready_i);
	assign cmd_fire    = cmd_valid_i & cmd_ready_o;

	// read mux
	always_comb
	begin
		case (cmd_i.addr)
			board_io_pkg::ADDR_OUT:  rd_data = out_q;
			board_io_pkg::ADDR_DIR:  rd_data = dir_q;
			board_io_pkg::ADDR_IN:   rd_data = level_i;	// live synced pins
			board_io_pkg::ADDR_EDGE: rd_data = edge_q;
			default:                 rd_data = '0;
		endcase
	end

	// clear mask, only for an accepted edge write
	always_comb
	begin
		edge_clr = '0;
		if (cmd_fire && cmd_i.write && cmd_i.addr == board_io_pkg::ADDR_EDGE)
			edge_clr = cmd_i.wdata;
	end

	// control state
	always_ff @(posedge clock_50mhz_i)
	begin
		if (reset_i)
		begin
			run_q       <= 1'b0;
			rsp_valid_q <= 1'b0;
			out_q       <= '0;	// all pads float
			dir_q       <= '0;
			edge_q      <= '0;
		end
		else
		begin
			run_q <= 1'b1;

			// response slot, fill wins over drain
			if (cmd_fire)
				rsp_valid_q <= 1'b1;
			else if (rsp_fire)
				rsp_valid_q <= 1'b0;

			// register writes land on the pads at this edge
			if (cmd_fire && cmd_i.write)
			begin
				case (cmd_i.addr)
					board_io_pkg::ADDR_OUT: out_q <= cmd_i.wdata;
					board_io_pkg::ADDR_DIR: dir_q <= cmd_i.wdata;
					default:
					begin
						out_q <= out_q;	// ADDR_IN read only, ADDR_EDGE via mask
					end
				endcase
			end

			// flags collect every cycle, bus or not
			// a same cycle rise beats the clear
			edge_q <= (edge_q & ~edge_clr) | rise_i;
		end
	end

	// response payload, held while the master stalls
	always_ff @(posedge clock_50mhz_i)
	begin
		if (cmd_fire)
		begin
			if (cmd_i.write)
				rsp_q.rdata <= '0;	// writes answer with zero
			else
				rsp_q.rdata <= rd_data;
		end
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = rsp_q;

	assign out_o = out_q;
	assign dir_o = dir_q;

endmodule

`default_nettype wire

// ==== board_io_top.sv ====
////////////////////
// board io top level, one clock domain
// pads drive out when dir is 1, else float
// pads always feed the synchronizer, outputs read back
////////////////////
`timescale 1ns/1ps
`default_nettype none

module board_io_top #(
	parameter int unsigned SYNC_STAGES = 2,		// synchronizer depth
	parameter int unsigned RESET_HOLD  = 16		// core reset stretch, cycles
) (
	input  logic                     clock_50mhz_i,
	input  logic                     reset2a_i,	// sync, active high

	inout  wire board_io_pkg::gpio_word_t gpio_io,	// bidirectional pads

	// register bus
	input  logic                     cmd_valid_i,
	output logic                     cmd_ready_o,
	input  board_io_pkg::gpio_cmd_t  cmd_i,
	output logic                     rsp_valid_o,
	input  logic                     rsp_ready_i,
	output board_io_pkg::gpio_rsp_t  rsp_o,

	output logic                     core_reset_o	// status
);

	logic                     core_reset;	// stretched reset for the core
	board_io_pkg::gpio_word_t pad_in;	// what the pads carry
	board_io_pkg::gpio_word_t pin_level;
	board_io_pkg::gpio_word_t pin_rise;
	board_io_pkg::gpio_word_t pad_out;
	board_io_pkg::gpio_word_t pad_dir;

	// tristate pads
	for (genvar i = 0; i < board_io_pkg::GPIO_WIDTH; i++)
	begin : g_pad
		assign gpio_io[i] = pad_dir[i] ? pad_out[i] : 1'bz;
	end
	assign pad_in = gpio_io;	// read back, driven or not

	reset_sequencer #(
		.RESET_HOLD (RESET_HOLD)
	) reset_sequencer_i (
		.clock_50mhz_i (clock_50mhz_i),
		.reset2a_i     (reset2a_i),
		.core_reset_o  (core_reset)
	);

	pin_synchronizer #(
		.SYNC_STAGES (SYNC_STAGES)
	) pin_synchronizer_i (
		.clock_50mhz_i (clock_50mhz_i),
		.reset_i       (core_reset),
		.pad_i         (pad_in),
		.level_o       (pin_level),
		.rise_o        (pin_rise)
	);

	gpio_regs gpio_regs_i (
		.clock_50mhz_i (clock_50mhz_i),
		.reset_i       (core_reset),
		.cmd_valid_i   (cmd_valid_i),
		.cmd_ready_o   (cmd_ready_o),
		.cmd_i         (cmd_i),
		.rsp_valid_o   (rsp_valid_o),
		.rsp_ready_i   (rsp_ready_i),
		.rsp_o         (rsp_o),
		.level_i       (pin_level),
		.rise_i        (pin_rise),
		.out_o         (pad_out),
		.dir_o         (pad_dir)
	);

	assign core_reset_o = core_reset;

endmodule

`default_nettype wire

// ==== board_io_tb.sv ====
////////////////////
// directed testbench for board_io_top
// pad model drives only where the tb copy of dir is 0
// inputs change and outputs are sampled on the falling edge
////////////////////
`timescale 1ns/1ps
`default_nettype none

module board_io_tb;

	localparam int unsigned SYNC_STAGES = 2;
	localparam int unsigned RESET_HOLD  = 16;
	localparam int unsigned PERIOD      = 20;	// ns at 50 MHz
	localparam int unsigned NUM_TESTS   = 5;
	localparam int unsigned LONGEST     = 300;	// cycles of the longest test
	localparam int unsigned MARGIN      = 4;
	localparam int unsigned BUS_LIMIT   = 50;	// cycles per handshake
	localparam int unsigned BURST_LEN   = 24;

	logic                     clock_50mhz;
	logic                     reset2a;
	logic                     cmd_valid;
	logic                     cmd_ready;
	board_io_pkg::gpio_cmd_t  cmd;
	logic                     rsp_valid;
	logic                     rsp_ready;
	board_io_pkg::gpio_rsp_t  rsp;
	logic                     core_reset;
	wire board_io_pkg::gpio_word_t gpio_io;

	board_io_pkg::gpio_word_t pad_drv;	// level the board puts on each pin
	board_io_pkg::gpio_word_t pad_en;	// board drives at all
	board_io_pkg::gpio_word_t m_out;	// expected register state
	board_io_pkg::gpio_word_t m_dir;	// also steers the pad model
	board_io_pkg::gpio_word_t m_edge;
	int unsigned              err_cnt;
	int unsigned              pass_cnt;
	int unsigned              seed_ret;

	board_io_top #(
		.SYNC_STAGES (SYNC_STAGES),
		.RESET_HOLD  (RESET_HOLD)
	) board_io_top_i (
		.clock_50mhz_i (clock_50mhz),
		.reset2a_i     (reset2a),
		.gpio_io       (gpio_io),
		.cmd_valid_i   (cmd_valid),
		.cmd_ready_o   (cmd_ready),
		.cmd_i         (cmd),
		.rsp_valid_o   (rsp_valid),
		.rsp_ready_i   (rsp_ready),
		.rsp_o         (rsp),
		.core_reset_o  (core_reset)
	);

	// board side of each pad backs off where the DUT drives
	for (genvar i = 0; i < board_io_pkg::GPIO_WIDTH; i++)
	begin : g_pad_model
		assign gpio_io[i] = (pad_en[i] && !m_dir[i]) ? pad_drv[i] : 1'bz;
	end

	initial
	begin
		clock_50mhz = 1'b0;
		forever #(PERIOD/2) clock_50mhz = ~clock_50mhz;
	end

	// run budget from test count and longest test
	initial
	begin
		#(NUM_TESTS * LONGEST * PERIOD * MARGIN);
		$display("timeout: the tests did not finish within the cycle budget");
		$display("=== FAIL ===");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] act,
		input logic [31:0] exp);
		if (act !== exp)
		begin
			$display("[FAIL] %0t ns %s actual %h expected %h", $time, name, act, exp);
			err_cnt++;
		end
		else
			pass_cnt++;
	endtask

	task automatic idle(input int unsigned n);
		repeat (n) @(negedge clock_50mhz);
	endtask

	// puts a command on the bus and returns at the negedge after the transfer
	task automatic send_cmd(input logic wr, input board_io_pkg::reg_addr_t addr,
		input board_io_pkg::gpio_word_t data);
		int unsigned n;
		n = 0;
		cmd_valid  = 1'b1;
		cmd.write  = wr;
		cmd.addr   = addr;
		cmd.wdata  = data;
		while (!cmd_ready && n < BUS_LIMIT)
		begin
			@(negedge clock_50mhz);
			n++;
		end
		if (!cmd_ready)
		begin
			$display("bus error at %0t ns: command was never accepted", $time);
			err_cnt++;
		end
		@(negedge clock_50mhz);	// transfer happened on the posedge between
		cmd_valid = 1'b0;
	endtask

	task automatic take_rsp(output board_io_pkg::gpio_word_t rdata);
		int unsigned n;
		n = 0;
		rsp_ready = 1'b1;
		while (!rsp_valid && n < BUS_LIMIT)
		begin
			@(negedge clock_50mhz);
			n++;
		end
		if (!rsp_valid)
		begin
			$display("bus error at %0t ns: no response arrived", $time);
			err_cnt++;
		end
		rdata = rsp.rdata;
		@(negedge clock_50mhz);
		rsp_ready = 1'b0;
	endtask

	task automatic bus_write(input board_io_pkg::reg_addr_t addr,
		input board_io_pkg::gpio_word_t data, output board_io_pkg::gpio_word_t rdata);
		send_cmd(1'b1, addr, data);
		if (addr == board_io_pkg::ADDR_DIR)
			m_dir = data;	// pad model follows the DUT drive enables
		take_rsp(rdata);
	endtask

	task automatic bus_read(input board_io_pkg::reg_addr_t addr,
		output board_io_pkg::gpio_word_t rdata);
		send_cmd(1'b0, addr, '0);
		take_rsp(rdata);
	endtask

	task automatic report(input int n, input string name, input int unsigned err0);
		$display("test %0d %s done, %0d mismatches", n, name, err_cnt - err0);
	endtask

	task automatic test_reset_release();
		int unsigned err0;
		int unsigned held;
		err0 = err_cnt;
		held = 0;
		reset2a = 1'b0;
		@(negedge clock_50mhz);
		while (core_reset && held < 4 * RESET_HOLD)
		begin
			check_value("cmd_ready_o", cmd_ready, 1'b0);	// no bus during reset
			held++;
			@(negedge clock_50mhz);
		end
		if (held < RESET_HOLD || core_reset)
		begin
			$display("core reset held %0d cycles, at least %0d expected", held, RESET_HOLD);
			err_cnt++;
		end
		check_value("gpio_io", gpio_io, {board_io_pkg::GPIO_WIDTH{1'bz}});
		report(1, "reset release", err0);
	endtask

	task automatic test_output_drive();
		int unsigned err0;
		board_io_pkg::gpio_word_t rd;
		board_io_pkg::gpio_word_t exp_pad;
		err0  = err_cnt;
		m_out = board_io_pkg::gpio_word_t'($urandom);
		bus_write(board_io_pkg::ADDR_OUT, m_out, rd);
		check_value("rsp_o write", rd, '0);
		bus_write(board_io_pkg::ADDR_DIR, board_io_pkg::gpio_word_t'($urandom), rd);
		check_value("rsp_o write", rd, '0);
		for (int i = 0; i < board_io_pkg::GPIO_WIDTH; i++)
			exp_pad[i] = m_dir[i] ? m_out[i] : 1'bz;	// floats until the model drives
		check_value("gpio_io", gpio_io, exp_pad);
		bus_read(board_io_pkg::ADDR_OUT, rd);
		check_value("out readback", rd, m_out);
		bus_read(board_io_pkg::ADDR_DIR, rd);
		check_value("dir readback", rd, m_dir);
		pad_en = '1;	// board takes the undriven pins from here on
		report(2, "output drive", err0);
	endtask

	task automatic test_input_levels();
		int unsigned err0;
		board_io_pkg::gpio_word_t rd;
		err0    = err_cnt;
		pad_drv = board_io_pkg::gpio_word_t'($urandom);
		idle(SYNC_STAGES + 2);
		bus_read(board_io_pkg::ADDR_IN, rd);
		// driven pins read their own out bit
		check_value("in mixed", rd, (m_dir & m_out) | (~m_dir & pad_drv));
		bus_write(board_io_pkg::ADDR_DIR, '0, rd);
		pad_drv = board_io_pkg::gpio_word_t'($urandom);
		idle(SYNC_STAGES + 2);
		bus_read(board_io_pkg::ADDR_IN, rd);
		check_value("in all inputs", rd, pad_drv);
		report(3, "input levels", err0);
	endtask

	task automatic test_edge_capture();
		int unsigned err0;
		board_io_pkg::gpio_word_t rd;
		board_io_pkg::gpio_word_t rose;
		board_io_pkg::gpio_word_t clr;
		err0    = err_cnt;
		pad_drv = '0;
		idle(SYNC_STAGES + 3);
		bus_write(board_io_pkg::ADDR_EDGE, '1, rd);	// start from clean flags
		m_edge = '0;
		bus_read(board_io_pkg::ADDR_EDGE, rd);
		check_value("edge cleared", rd, m_edge);
		rose    = board_io_pkg::gpio_word_t'($urandom) | 16'h0001;
		pad_drv = rose;
		idle(SYNC_STAGES + 3);
		pad_drv = '0;	// fall again while the flags stay
		idle(SYNC_STAGES + 3);
		m_edge = rose;
		bus_read(board_io_pkg::ADDR_EDGE, rd);
		check_value("edge sticky", rd, m_edge);
		clr = rose & board_io_pkg::gpio_word_t'($urandom);
		bus_write(board_io_pkg::ADDR_EDGE, clr, rd);
		m_edge = m_edge & ~clr;
		bus_read(board_io_pkg::ADDR_EDGE, rd);
		check_value("edge partial clear", rd, m_edge);
		bus_write(board_io_pkg::ADDR_IN, board_io_pkg::gpio_word_t'($urandom), rd);
		check_value("rsp_o write", rd, '0);
		bus_read(board_io_pkg::ADDR_OUT, rd);
		check_value("out after in write", rd, m_out);
		bus_read(board_io_pkg::ADDR_DIR, rd);
		check_value("dir after in write", rd, m_dir);
		bus_read(board_io_pkg::ADDR_EDGE, rd);
		check_value("edge after in write", rd, m_edge);
		bus_read(board_io_pkg::ADDR_IN, rd);
		check_value("in after in write", rd, pad_drv);
		report(4, "edge capture", err0);
	endtask

	task automatic test_back_pressure();
		int unsigned err0;
		int unsigned stall;
		logic wr;
		board_io_pkg::reg_addr_t  addr;
		board_io_pkg::gpio_word_t data;
		board_io_pkg::gpio_word_t exp_q[$];
		err0    = err_cnt;
		pad_drv = board_io_pkg::gpio_word_t'($urandom);	// pins were all low
		idle(SYNC_STAGES + 3);
		m_edge = m_edge | pad_drv;
		send_cmd(1'b0, board_io_pkg::ADDR_OUT, '0);
		// next command waits on the bus through the stall
		cmd_valid = 1'b1;
		cmd.write = 1'b0;
		cmd.addr  = board_io_pkg::ADDR_IN;
		cmd.wdata = '0;
		stall = $urandom_range(12, 3);
		for (int k = 0; k < stall; k++)
		begin
			check_value("rsp_valid_o stall", rsp_valid, 1'b1);
			check_value("rsp_o stall", rsp.rdata, m_out);
			check_value("cmd_ready_o stall", cmd_ready, 1'b0);
			@(negedge clock_50mhz);
		end
		rsp_ready = 1'b1;
		@(negedge clock_50mhz);
		cmd_valid = 1'b0;	// taken with the first response
		check_value("rsp_valid_o refill", rsp_valid, 1'b1);
		check_value("rsp_o refill", rsp.rdata, pad_drv);
		@(negedge clock_50mhz);
		check_value("rsp_valid_o drained", rsp_valid, 1'b0);
		for (int i = 0; i <= BURST_LEN; i++)
		begin
			if (i > 0)
			begin
				check_value("rsp_valid_o burst", rsp_valid, 1'b1);
				check_value("rsp_o burst", rsp.rdata, exp_q.pop_front());
			end
			if (i < BURST_LEN)
			begin
				check_value("cmd_ready_o burst", cmd_ready, 1'b1);
				wr   = 1'($urandom);
				addr = board_io_pkg::reg_addr_t'($urandom);
				data = board_io_pkg::gpio_word_t'($urandom);
				if (wr && addr == board_io_pkg::ADDR_DIR)
					addr = board_io_pkg::ADDR_OUT;	// keep the pins steady
				if (wr)
				begin
					exp_q.push_back('0);
					if (addr == board_io_pkg::ADDR_OUT)
						m_out = data;
					else if (addr == board_io_pkg::ADDR_EDGE)
						m_edge = m_edge & ~data;
				end
				else
				begin
					case (addr)
						board_io_pkg::ADDR_OUT: exp_q.push_back(m_out);
						board_io_pkg::ADDR_DIR: exp_q.push_back(m_dir);
						board_io_pkg::ADDR_IN:  exp_q.push_back(pad_drv);
						default:                exp_q.push_back(m_edge);
					endcase
				end
				cmd_valid = 1'b1;
				cmd.write = wr;
				cmd.addr  = addr;
				cmd.wdata = data;
			end
			else
				cmd_valid = 1'b0;
			@(negedge clock_50mhz);
		end
		check_value("rsp_valid_o idle", rsp_valid, 1'b0);
		rsp_ready = 1'b0;
		report(5, "back-pressure", err0);
	endtask

	initial
	begin
		seed_ret  = $urandom(32'h7d8a222a);
		reset2a   = 1'b1;
		cmd_valid = 1'b0;
		cmd       = '0;
		rsp_ready = 1'b0;
		pad_drv   = '0;
		pad_en    = '0;	// all pins float until test 2
		m_out     = '0;
		m_dir     = '0;
		m_edge    = '0;
		err_cnt   = 0;
		pass_cnt  = 0;
		repeat (3) @(negedge clock_50mhz);	// reset2a over 3 rising edges
		test_reset_release();
		test_output_drive();
		test_input_levels();
		test_edge_capture();
		test_back_pressure();
		$display("checks passed %0d, failed %0d", pass_cnt, err_cnt);
		if (err_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== board_io.f ====
board_io_pkg.sv
reset_sequencer.sv
pin_synchronizer.sv
gpio_regs.sv
board_io_top.sv
board_io_tb.sv

// ==== Bender.yml ====
package:
  name: board_io

sources:
  - board_io_pkg.sv
  - reset_sequencer.sv
  - pin_synchronizer.sv
  - gpio_regs.sv
  - board_io_top.sv
  - target: simulation
    files:
      - board_io_tb.sv
